// ==== sources.f ====
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/tile_map_mem.sv
hdl/player_controller.sv
hdl/bomb_dispatch.sv
hdl/bomb_fuse_slot.sv
hdl/map_write_arbiter.sv
hdl/pixel_renderer.sv
hdl/game_top.sv
bench/game_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= game_top_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/game_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_top_tb;
  import game_pkg::*;

  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // Last checked frame, counted from reset
  localparam int TEST_FRAMES  = 17;
  // Room for reset, the lock frame and some margin
  localparam int MAX_CYCLES   = (TEST_FRAMES + 3) * FRAME_CYCLES;

  logic       pixclk;
  logic       rst_n;
  logic       up;
  logic       down;
  logic       left;
  logic       right;
  logic       place_bomb;
  logic [3:0] pix_r;
  logic [3:0] pix_g;
  logic [3:0] pix_b;
  logic       hsync;
  logic       vsync;
  rgb_t       pix;

  // Reference model of the playfield
  tile_t ref_map [MAP_DEPTH];
  int    ref_row;
  int    ref_col;
  bit    ref_active [NUM_BOMB_SLOTS];
  int    ref_addr [NUM_BOMB_SLOTS];
  int    ref_fuse [NUM_BOMB_SLOTS];

  // Scan position recovered from the sync outputs
  logic  hs_q;
  logic  vs_q;
  bit    locked;
  int    sx;
  int    sy;
  int    hs_low;
  int    hs_gap;
  bit    hs_seen;
  int    vs_low;
  rgb_t  exp_color;

  string cur_test;
  int    test_checks;
  int    test_errors;
  int    sync_checks;
  int    sync_errors;
  int    tests_passed;
  int    tests_failed;
  int    cycle_count;
  int    seed;
  int    dir;

  event  frame_done;

  assign pix = {pix_r, pix_g, pix_b};

  game_top dut_i (
    .pixclk       (pixclk),
    .i_rst_n      (rst_n),
    .i_up         (up),
    .i_down       (down),
    .i_left       (left),
    .i_right      (right),
    .i_place_bomb (place_bomb),
    .o_pix_r      (pix_r),
    .o_pix_g      (pix_g),
    .o_pix_b      (pix_b),
    .o_hsync      (hsync),
    .o_vsync      (vsync)
  );

  initial pixclk = 1'b0;
  always #10 pixclk = ~pixclk;

  function automatic bit wall_at(input int r, input int c);
    return (r == 0) || (r == MAP_ROWS - 1) || (c == 0) || (c == MAP_COLS - 1) ||
           ((r % 2 == 0) && (c % 2 == 0));
  endfunction

  function automatic tile_t start_tile(input int r, input int c);
    bit corner;
    corner = (r >= 1) && (r <= 3) && (c >= 1) && (c <= 3);
    if (wall_at(r, c)) begin
      return TILE_HARD;
    end
    if (((r + c) % 3 == 0) && !corner) begin
      return TILE_SOFT;
    end
    return TILE_EMPTY;
  endfunction

  function automatic rgb_t expected_tile_color(input int row, input int col);
    rgb_t color;
    case (ref_map[row * MAP_COLS + col])
      TILE_HARD: color = C_HARD;
      TILE_SOFT: color = C_SOFT;
      TILE_BOMB: color = C_BOMB;
      default:   color = C_EMPTY;
    endcase
    // Player block covers any tile
    if (row == ref_row && col == ref_col) begin
      color = C_PLAYER;
    end
    return color;
  endfunction

  task automatic reset_model();
    for (int r = 0; r < MAP_ROWS; r++) begin
      for (int c = 0; c < MAP_COLS; c++) begin
        ref_map[r * MAP_COLS + c] = start_tile(r, c);
      end
    end
    ref_row = PLAYER_INIT_ROW;
    ref_col = PLAYER_INIT_COL;
    for (int s = 0; s < NUM_BOMB_SLOTS; s++) begin
      ref_active[s] = 1'b0;
      ref_addr[s]   = 0;
      ref_fuse[s]   = 0;
    end
  endtask

  task automatic clear_if_open(input int r, input int c);
    if (!wall_at(r, c)) begin
      ref_map[r * MAP_COLS + c] = TILE_EMPTY;
    end
  endtask

  task automatic blast_tiles(input int addr);
    int r;
    int c;
    r = addr / MAP_COLS;
    c = addr % MAP_COLS;
    ref_map[addr] = TILE_EMPTY;
    clear_if_open(r - 1, c);
    clear_if_open(r + 1, c);
    clear_if_open(r, c - 1);
    clear_if_open(r, c + 1);
  endtask

  // One frame of game rules, applied at the frame tick
  task automatic step_model(input bit mv_up, input bit mv_down, input bit mv_left,
                            input bit mv_right, input bit place);
    int dr;
    int dc;
    int old_addr;
    int free_slot;
    bit dup;
    bit fire [NUM_BOMB_SLOTS];
    dr       = ref_row;
    dc       = ref_col;
    old_addr = ref_row * MAP_COLS + ref_col;
    if (mv_up) begin
      dr = ref_row - 1;
    end else if (mv_down) begin
      dr = ref_row + 1;
    end else if (mv_left) begin
      dc = ref_col - 1;
    end else if (mv_right) begin
      dc = ref_col + 1;
    end
    // Collision read sees the map before this frame's writes
    if (ref_map[dr * MAP_COLS + dc] == TILE_EMPTY) begin
      ref_row = dr;
      ref_col = dc;
    end
    dup       = 1'b0;
    free_slot = -1;
    for (int s = 0; s < NUM_BOMB_SLOTS; s++) begin
      fire[s] = 1'b0;
      if (ref_active[s]) begin
        ref_fuse[s]++;
        fire[s] = (ref_fuse[s] == FUSE_FRAMES);
        if (ref_addr[s] == old_addr) begin
          dup = 1'b1;
        end
      end else if (free_slot < 0) begin
        free_slot = s;
      end
    end
    // Exploding slots still count as busy for the dispatcher
    for (int s = 0; s < NUM_BOMB_SLOTS; s++) begin
      if (fire[s]) begin
        blast_tiles(ref_addr[s]);
        ref_active[s] = 1'b0;
      end
    end
    if (place && !dup && free_slot >= 0) begin
      ref_active[free_slot] = 1'b1;
      ref_addr[free_slot]   = old_addr;
      ref_fuse[free_slot]   = 0;
      ref_map[old_addr]     = TILE_BOMB;
    end
  endtask

  always @(posedge pixclk) begin
    if (rst_n) begin
      if (locked) begin
        if (sx == H_TOTAL - 1) begin
          sx = 0;
          sy = (sy == V_TOTAL - 1) ? 0 : sy + 1;
        end else begin
          sx = sx + 1;
        end
      end
      hs_gap = hs_gap + 1;
      if (hs_q && !hsync) begin
        // Output pixel is the first one of the hsync window
        sx = H_SYNC_START;
        if (hs_seen) begin
          sync_checks++;
          assert (hs_gap == H_TOTAL) else begin
            $display("MISMATCH sync_timing: hsync period expected %0d actual %0d",
                     H_TOTAL, hs_gap);
            sync_errors++;
          end
        end
        hs_seen = 1'b1;
        hs_gap  = 0;
      end
      if (!hsync) begin
        hs_low++;
      end
      if (!hs_q && hsync) begin
        sync_checks++;
        assert (hs_low == H_SYNC) else begin
          $display("MISMATCH sync_timing: hsync low width expected %0d actual %0d",
                   H_SYNC, hs_low);
          sync_errors++;
        end
        hs_low = 0;
      end
      if (!vsync) begin
        vs_low++;
      end
      if (!vs_q && vsync) begin
        sync_checks++;
        assert (vs_low == V_SYNC * H_TOTAL) else begin
          $display("MISMATCH sync_timing: vsync low width expected %0d actual %0d",
                   V_SYNC * H_TOTAL, vs_low);
          sync_errors++;
        end
        vs_low = 0;
      end
      if (vs_q && !vsync) begin
        sx     = 0;
        sy     = V_SYNC_START;
        locked = 1'b1;
      end
      if (locked) begin
        if (sx >= H_VISIBLE || sy >= V_VISIBLE) begin
          sync_checks++;
          assert (pix == C_EMPTY) else begin
            $display("MISMATCH sync_timing: blank pixel (%0d,%0d) expected %03h actual %03h",
                     sx, sy, C_EMPTY, pix);
            sync_errors++;
          end
        end else if ((sx % TILE_PX == TILE_PX / 2) && (sy % TILE_PX == TILE_PX / 2)) begin
          exp_color = expected_tile_color(sy / TILE_PX, sx / TILE_PX);
          test_checks++;
          assert (pix == exp_color) else begin
            $display("MISMATCH %s: tile row %0d col %0d expected %03h actual %03h",
                     cur_test, sy / TILE_PX, sx / TILE_PX, exp_color, pix);
            test_errors++;
          end
        end
        if (sx == 0 && sy == V_VISIBLE) begin
          -> frame_done;
        end
        // Model catches up with the tick before the next frame is scanned
        if (sx == H_TOTAL - 1 && sy == V_TOTAL - 1) begin
          step_model(up, down, left, right, place_bomb);
        end
      end
    end
    hs_q = hsync;
    vs_q = vsync;
  end

  always @(posedge pixclk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_test(input string name, input int checks, input int errors);
    if (checks == 0) begin
      $display("%s: no checks were made during the test", name);
      errors++;
    end
    $display("test %s: %s (%0d checks, %0d errors)", name,
             (errors == 0) ? "PASS" : "FAIL", checks, errors);
    if (errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
  endtask

  // Inputs hold for one whole frame, then the frame's checks are done
  task automatic play_frame(input bit mv_up, input bit mv_down, input bit mv_left,
                            input bit mv_right, input bit place);
    up         <= mv_up;
    down       <= mv_down;
    left       <= mv_left;
    right      <= mv_right;
    place_bomb <= place;
    @(frame_done);
  endtask

  initial begin
    rst_n        = 1'b0;
    up           = 1'b0;
    down         = 1'b0;
    left         = 1'b0;
    right        = 1'b0;
    place_bomb   = 1'b0;
    hs_q         = 1'b1;
    vs_q         = 1'b1;
    locked       = 1'b0;
    sx           = 0;
    sy           = 0;
    hs_low       = 0;
    hs_gap       = 0;
    hs_seen      = 1'b0;
    vs_low       = 0;
    sync_checks  = 0;
    sync_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  = 0;
    seed         = 77337;
    start_test("reset_map");
    reset_model();
    repeat (10) @(posedge pixclk);
    rst_n <= 1'b1;

    @(frame_done);
    report_test(cur_test, test_checks, test_errors);

    start_test("move_empty");
    play_frame(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    play_frame(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    play_frame(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    play_frame(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    report_test(cur_test, test_checks, test_errors);

    // From (3,3) a hard pillar lies above (3,4) and soft bricks around (3,5)
    start_test("move_blocked");
    play_frame(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    play_frame(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    play_frame(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    play_frame(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    report_test(cur_test, test_checks, test_errors);

    // Third request comes while both slots are busy
    start_test("bomb_place");
    play_frame(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    play_frame(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    play_frame(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    report_test(cur_test, test_checks, test_errors);

    // First blast also clears the second bomb's tile
    start_test("bomb_blast");
    play_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    play_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    report_test(cur_test, test_checks, test_errors);

    start_test("random_walk");
    repeat (3) begin
      dir = $unsigned($random(seed)) % 4;
      play_frame(dir == 0, dir == 1, dir == 2, dir == 3, 1'b0);
    end
    report_test(cur_test, test_checks, test_errors);

    report_test("sync_timing", sync_checks, sync_errors);

    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_top (
  input  logic       pixclk,
  input  logic       i_rst_n,
  input  logic       i_up,
  input  logic       i_down,
  input  logic       i_left,
  input  logic       i_right,
  input  logic       i_place_bomb,
  output logic [3:0] o_pix_r,
  output logic [3:0] o_pix_g,
  output logic [3:0] o_pix_b,
  output logic       o_hsync,
  output logic       o_vsync
);
  import game_pkg::*;

  pix_x_t    pix_x;
  pix_y_t    pix_y;
  logic      visible;
  logic      hsync_raw;
  logic      vsync_raw;
  logic      tick;

  map_addr_t rd1_addr;
  tile_t     rd1_data;
  map_addr_t rd2_addr;
  tile_t     rd2_data;
  logic      we;
  map_addr_t wr_addr;
  tile_t     wr_data;

  tile_col_t player_col;
  tile_row_t player_row;
  map_addr_t player_addr;

  logic [NUM_BOMB_SLOTS-1:0]      slot_active;
  logic [NUM_BOMB_SLOTS-1:0]      slot_load;
  logic [NUM_BOMB_SLOTS-1:0]      slot_req;
  logic [NUM_BOMB_SLOTS-1:0]      slot_grant;
  map_addr_t [NUM_BOMB_SLOTS-1:0] slot_addr;
  map_addr_t [NUM_BOMB_SLOTS-1:0] slot_req_addr;
  tile_t [NUM_BOMB_SLOTS-1:0]     slot_req_data;
  map_addr_t                      load_addr;

  assign player_addr = tile_addr(player_row, player_col);

  vga_timing timing_i (
    .pixclk    (pixclk),
    .i_rst_n   (i_rst_n),
    .o_pix_x   (pix_x),
    .o_pix_y   (pix_y),
    .o_visible (visible),
    .o_hsync   (hsync_raw),
    .o_vsync   (vsync_raw),
    .o_tick    (tick)
  );

  // Port 1 serves collision checks, port 2 the renderer
  tile_map_mem map_i (
    .pixclk     (pixclk),
    .i_rd1_addr (rd1_addr),
    .o_rd1_data (rd1_data),
    .i_rd2_addr (rd2_addr),
    .o_rd2_data (rd2_data),
    .i_we       (we),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data)
  );

  player_controller player_i (
    .pixclk       (pixclk),
    .i_rst_n      (i_rst_n),
    .i_tick       (tick),
    .i_up         (i_up),
    .i_down       (i_down),
    .i_left       (i_left),
    .i_right      (i_right),
    .o_map_addr   (rd1_addr),
    .i_map_tile   (rd1_data),
    .o_player_col (player_col),
    .o_player_row (player_row)
  );

  bomb_dispatch dispatch_i (
    .pixclk        (pixclk),
    .i_rst_n       (i_rst_n),
    .i_tick        (tick),
    .i_place_bomb  (i_place_bomb),
    .i_player_addr (player_addr),
    .i_slot_active (slot_active),
    .i_slot_addr   (slot_addr),
    .o_load        (slot_load),
    .o_load_addr   (load_addr)
  );

  for (genvar s = 0; s < NUM_BOMB_SLOTS; s++) begin : g_slot
    bomb_fuse_slot slot_i (
      .pixclk      (pixclk),
      .i_rst_n     (i_rst_n),
      .i_tick      (tick),
      .i_load      (slot_load[s]),
      .i_load_addr (load_addr),
      .o_active    (slot_active[s]),
      .o_addr      (slot_addr[s]),
      .o_req       (slot_req[s]),
      .o_req_addr  (slot_req_addr[s]),
      .o_req_data  (slot_req_data[s]),
      .i_grant     (slot_grant[s])
    );
  end

  map_write_arbiter arbiter_i (
    .pixclk     (pixclk),
    .i_rst_n    (i_rst_n),
    .i_req      (slot_req),
    .i_req_addr (slot_req_addr),
    .i_req_data (slot_req_data),
    .o_grant    (slot_grant),
    .o_we       (we),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data)
  );

  pixel_renderer renderer_i (
    .pixclk       (pixclk),
    .i_rst_n      (i_rst_n),
    .i_pix_x      (pix_x),
    .i_pix_y      (pix_y),
    .i_visible    (visible),
    .i_hsync      (hsync_raw),
    .i_vsync      (vsync_raw),
    .i_player_col (player_col),
    .i_player_row (player_row),
    .o_map_addr   (rd2_addr),
    .i_map_tile   (rd2_data),
    .o_pix_r      (o_pix_r),
    .o_pix_g      (o_pix_g),
    .o_pix_b      (o_pix_b),
    .o_hsync      (o_hsync),
    .o_vsync      (o_vsync)
  );

endmodule

`default_nettype wire

// ==== hdl/pixel_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_renderer (
  input  logic                pixclk,
  input  logic                i_rst_n,
  input  game_pkg::pix_x_t    i_pix_x,
  input  game_pkg::pix_y_t    i_pix_y,
  input  logic                i_visible,
  input  logic                i_hsync,
  input  logic                i_vsync,
  input  game_pkg::tile_col_t i_player_col,
  input  game_pkg::tile_row_t i_player_row,
  output game_pkg::map_addr_t o_map_addr,
  input  game_pkg::tile_t     i_map_tile,
  output logic [3:0]          o_pix_r,
  output logic [3:0]          o_pix_g,
  output logic [3:0]          o_pix_b,
  output logic                o_hsync,
  output logic                o_vsync
);
  import game_pkg::*;

  tile_col_t col;
  tile_row_t row;
  logic      vis_q;
  logic      player_q;
  logic      hsync_q;
  logic      vsync_q;
  rgb_t      color_d;
  rgb_t      color_q;

  assign col = tile_col_t'(i_pix_x / TILE_PX);
  assign row = tile_row_t'(i_pix_y / TILE_PX);
  // Blanking rows and columns would index past the map
  assign o_map_addr = i_visible ? tile_addr(row, col) : '0;

  // Stage 1 lines up with the map read
  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      vis_q    <= 1'b0;
      player_q <= 1'b0;
      hsync_q  <= 1'b1;
      vsync_q  <= 1'b1;
    end else begin
      vis_q    <= i_visible;
      player_q <= i_visible && (col == i_player_col) && (row == i_player_row);
      hsync_q  <= i_hsync;
      vsync_q  <= i_vsync;
    end
  end

  always_comb begin
    if (!vis_q) begin
      color_d = C_EMPTY;
    end else if (player_q) begin
      color_d = C_PLAYER;
    end else begin
      case (i_map_tile)
        TILE_HARD: color_d = C_HARD;
        TILE_SOFT: color_d = C_SOFT;
        TILE_BOMB: color_d = C_BOMB;
        default:   color_d = C_EMPTY;
      endcase
    end
  end

  // Stage 2 output register
  always_ff @(posedge pixclk) begin
    color_q <= color_d;
  end

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
    end else begin
      o_hsync <= hsync_q;
      o_vsync <= vsync_q;
    end
  end

  assign o_pix_r = color_q[11:8];
  assign o_pix_g = color_q[7:4];
  assign o_pix_b = color_q[3:0];

endmodule

`default_nettype wire

// ==== hdl/map_write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_write_arbiter (
  input  logic                                               pixclk,
  input  logic                                               i_rst_n,
  input  logic [game_pkg::NUM_BOMB_SLOTS-1:0]                i_req,
  input  game_pkg::map_addr_t [game_pkg::NUM_BOMB_SLOTS-1:0] i_req_addr,
  input  game_pkg::tile_t [game_pkg::NUM_BOMB_SLOTS-1:0]     i_req_data,
  output logic [game_pkg::NUM_BOMB_SLOTS-1:0]                o_grant,
  output logic                                               o_we,
  output game_pkg::map_addr_t                                o_wr_addr,
  output game_pkg::tile_t                                    o_wr_data
);
  import game_pkg::*;

  logic found;

  // Lowest index wins
  always_comb begin
    o_grant = '0;
    found   = 1'b0;
    for (int s = 0; s < NUM_BOMB_SLOTS; s++) begin
      if (i_req[s] && !found) begin
        o_grant[s] = 1'b1;
        found      = 1'b1;
      end
    end
  end

  always_comb begin
    o_wr_addr = '0;
    o_wr_data = TILE_EMPTY;
    for (int s = 0; s < NUM_BOMB_SLOTS; s++) begin
      if (o_grant[s]) begin
        o_wr_addr = i_req_addr[s];
        o_wr_data = i_req_data[s];
      end
    end
  end

  assign o_we = |o_grant;

  a_grant_onehot: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    $onehot0(o_grant));

  // A waiting slot keeps its write steady until it is served
  for (genvar s = 0; s < NUM_BOMB_SLOTS; s++) begin : g_hold
    a_req_held: assert property (@(posedge pixclk) disable iff (!i_rst_n)
      i_req[s] && !o_grant[s] |=>
        i_req[s] && $stable(i_req_addr[s]) && $stable(i_req_data[s]));
  end

endmodule

`default_nettype wire

// ==== hdl/bomb_fuse_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomb_fuse_slot (
  input  logic                pixclk,
  input  logic                i_rst_n,
  input  logic                i_tick,
  input  logic                i_load,
  input  game_pkg::map_addr_t i_load_addr,
  output logic                o_active,
  output game_pkg::map_addr_t o_addr,
  output logic                o_req,
  output game_pkg::map_addr_t o_req_addr,
  output game_pkg::tile_t     o_req_data,
  input  logic                i_grant
);
  import game_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    PLACE,
    FUSE,
    BLAST
  } state_t;

  state_t                  state;
  map_addr_t               addr_q;
  fuse_cnt_t               fuse_cnt;
  logic                    fuse_fire;
  blast_step_t             step;
  blast_step_t             next_step;
  logic                    last_step;
  tile_row_t               row;
  tile_col_t               col;
  logic [BLAST_WRITES-1:1] blast_ok;
  map_addr_t               step_addr;

  always_ff @(posedge pixclk) begin
    if (state == IDLE && i_load) begin
      addr_q <= i_load_addr;
    end
  end

  assign row = tile_row_t'(addr_q / MAP_COLS);
  assign col = tile_col_t'(addr_q % MAP_COLS);

  // Bombs sit off the border, so every neighbour is inside the map
  assign blast_ok[1] = !is_hard_wall(tile_row_t'(row - 1'b1), col);
  assign blast_ok[2] = !is_hard_wall(tile_row_t'(row + 1'b1), col);
  assign blast_ok[3] = !is_hard_wall(row, tile_col_t'(col - 1'b1));
  assign blast_ok[4] = !is_hard_wall(row, tile_col_t'(col + 1'b1));

  // Next write after the current one, hard neighbours skipped
  always_comb begin
    next_step = step;
    last_step = 1'b1;
    for (int s = BLAST_WRITES - 1; s >= 1; s--) begin
      if (s > step && blast_ok[s]) begin
        next_step = blast_step_t'(s);
        last_step = 1'b0;
      end
    end
  end

  always_comb begin
    case (step)
      3'd0:    step_addr = addr_q;
      3'd1:    step_addr = map_addr_t'(addr_q - MAP_COLS);
      3'd2:    step_addr = map_addr_t'(addr_q + MAP_COLS);
      3'd3:    step_addr = addr_q - 1'b1;
      default: step_addr = addr_q + 1'b1;
    endcase
  end

  // Fuse ends on the last tick, or already ended while placement waited
  assign fuse_fire = (fuse_cnt == FUSE_FRAMES) ||
                     (i_tick && fuse_cnt == FUSE_FRAMES - 1);

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      state    <= IDLE;
      fuse_cnt <= '0;
      step     <= '0;
    end else begin
      if ((state == PLACE || state == FUSE) && i_tick && fuse_cnt != FUSE_FRAMES) begin
        fuse_cnt <= fuse_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          if (i_load) begin
            state    <= PLACE;
            fuse_cnt <= '0;
          end
        end
        PLACE: begin
          if (i_grant) begin
            state <= fuse_fire ? BLAST : FUSE;
            step  <= '0;
          end
        end
        FUSE: begin
          if (fuse_fire) begin
            state <= BLAST;
            step  <= '0;
          end
        end
        BLAST: begin
          if (i_grant) begin
            if (last_step) begin
              state <= IDLE;
            end else begin
              step <= next_step;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign o_active   = (state != IDLE);
  assign o_addr     = addr_q;
  assign o_req      = (state == PLACE) || (state == BLAST);
  assign o_req_addr = (state == PLACE) ? addr_q : step_addr;
  assign o_req_data = (state == PLACE) ? TILE_BOMB : TILE_EMPTY;

endmodule

`default_nettype wire

// ==== hdl/bomb_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module bomb_dispatch (
  input  logic                                               pixclk,
  input  logic                                               i_rst_n,
  input  logic                                               i_tick,
  input  logic                                               i_place_bomb,
  input  game_pkg::map_addr_t                                i_player_addr,
  input  logic [game_pkg::NUM_BOMB_SLOTS-1:0]                i_slot_active,
  input  game_pkg::map_addr_t [game_pkg::NUM_BOMB_SLOTS-1:0] i_slot_addr,
  output logic [game_pkg::NUM_BOMB_SLOTS-1:0]                o_load,
  output game_pkg::map_addr_t                                o_load_addr
);
  import game_pkg::*;

  logic                      req_q;
  map_addr_t                 addr_q;
  logic                      dup;
  logic                      found;
  logic [NUM_BOMB_SLOTS-1:0] free_onehot;

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= i_tick & i_place_bomb;
    end
  end

  always_ff @(posedge pixclk) begin
    if (i_tick) begin
      addr_q <= i_player_addr;
    end
  end

  always_comb begin
    dup         = 1'b0;
    found       = 1'b0;
    free_onehot = '0;
    for (int s = 0; s < NUM_BOMB_SLOTS; s++) begin
      // One bomb per tile
      if (i_slot_active[s] && i_slot_addr[s] == addr_q) begin
        dup = 1'b1;
      end
      if (!i_slot_active[s] && !found) begin
        free_onehot[s] = 1'b1;
        found          = 1'b1;
      end
    end
  end

  // No idle slot means the request is lost
  assign o_load      = (req_q && !dup) ? free_onehot : '0;
  assign o_load_addr = addr_q;

  a_load_onehot: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    $onehot0(o_load));

endmodule

`default_nettype wire

// ==== hdl/player_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_controller (
  input  logic                  pixclk,
  input  logic                  i_rst_n,
  input  logic                  i_tick,
  input  logic                  i_up,
  input  logic                  i_down,
  input  logic                  i_left,
  input  logic                  i_right,
  output game_pkg::map_addr_t   o_map_addr,
  input  game_pkg::tile_t       i_map_tile,
  output game_pkg::tile_col_t   o_player_col,
  output game_pkg::tile_row_t   o_player_row
);
  import game_pkg::*;

  typedef enum logic {
    IDLE,
    CHECK
  } state_t;

  state_t    state;
  tile_col_t dest_col;
  tile_row_t dest_row;
  tile_col_t dest_col_q;
  tile_row_t dest_row_q;
  logic      want_move;

  // Destination tile, up wins over down, left and right
  always_comb begin
    dest_col = o_player_col;
    dest_row = o_player_row;
    if (i_up) begin
      dest_row = o_player_row - 1'b1;
    end else if (i_down) begin
      dest_row = o_player_row + 1'b1;
    end else if (i_left) begin
      dest_col = o_player_col - 1'b1;
    end else if (i_right) begin
      dest_col = o_player_col + 1'b1;
    end
  end

  assign want_move  = i_up | i_down | i_left | i_right;
  // Read is launched in the tick cycle
  assign o_map_addr = tile_addr(dest_row, dest_col);

  always_ff @(posedge pixclk) begin
    if (i_tick && state == IDLE) begin
      dest_col_q <= dest_col;
      dest_row_q <= dest_row;
    end
  end

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      state        <= IDLE;
      o_player_col <= tile_col_t'(PLAYER_INIT_COL);
      o_player_row <= tile_row_t'(PLAYER_INIT_ROW);
    end else begin
      case (state)
        IDLE: begin
          if (i_tick && want_move) begin
            state <= CHECK;
          end
        end
        CHECK: begin
          // Tile data for the destination is valid now
          if (i_map_tile == TILE_EMPTY) begin
            o_player_col <= dest_col_q;
            o_player_row <= dest_row_q;
          end
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Walls are never written, so the map read must keep the player off them
  a_no_hard_wall: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    !is_hard_wall(o_player_row, o_player_col));

endmodule

`default_nettype wire

// ==== hdl/tile_map_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_map_mem (
  input  logic                pixclk,
  input  game_pkg::map_addr_t i_rd1_addr,
  output game_pkg::tile_t     o_rd1_data,
  input  game_pkg::map_addr_t i_rd2_addr,
  output game_pkg::tile_t     o_rd2_data,
  input  logic                i_we,
  input  game_pkg::map_addr_t i_wr_addr,
  input  game_pkg::tile_t     i_wr_data
);
  import game_pkg::*;

  tile_t mem [MAP_DEPTH];

  // Power-up contents come from the map rule
  initial begin
    for (int r = 0; r < MAP_ROWS; r++) begin
      for (int c = 0; c < MAP_COLS; c++) begin
        mem[r * MAP_COLS + c] = init_tile(tile_row_t'(r), tile_col_t'(c));
      end
    end
  end

  // Reads return the old tile when a write hits the same address
  always_ff @(posedge pixclk) begin
    if (i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd1_data <= mem[i_rd1_addr];
    o_rd2_data <= mem[i_rd2_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
  input  logic              pixclk,
  input  logic              i_rst_n,
  output game_pkg::pix_x_t  o_pix_x,
  output game_pkg::pix_y_t  o_pix_y,
  output logic              o_visible,
  output logic              o_hsync,
  output logic              o_vsync,
  output logic              o_tick
);
  import game_pkg::*;

  pix_x_t h_cnt;
  pix_y_t v_cnt;

  always_ff @(posedge pixclk) begin
    if (!i_rst_n) begin
      h_cnt  <= '0;
      v_cnt  <= '0;
      o_tick <= 1'b0;
    end else begin
      // Frame start, seen one cycle after (0,0)
      o_tick <= (h_cnt == 0) && (v_cnt == 0);
      if (h_cnt == H_TOTAL - 1) begin
        h_cnt <= '0;
        if (v_cnt == V_TOTAL - 1) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign o_pix_x   = h_cnt;
  assign o_pix_y   = v_cnt;
  assign o_visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
  assign o_hsync   = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
  assign o_vsync   = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

  // Player and bomb logic count on one step per frame
  a_tick_single: assert property (@(posedge pixclk) disable iff (!i_rst_n)
    o_tick |=> !o_tick);

endmodule

`default_nettype wire

// ==== hdl/game_pkg.sv ====
`default_nettype none

package game_pkg;

  // 640x480 VGA timing
  localparam int H_VISIBLE = 640;
  localparam int H_FRONT   = 16;
  localparam int H_SYNC    = 96;
  localparam int H_BACK    = 48;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_VISIBLE = 480;
  localparam int V_FRONT   = 10;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 33;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  // Sync windows, both pulses active low
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  // Playfield
  localparam int TILE_PX    = 32;
  localparam int MAP_COLS   = 20;
  localparam int MAP_ROWS   = 15;
  localparam int MAP_DEPTH  = MAP_COLS * MAP_ROWS;
  localparam int MAP_ADDR_W = 9;

  // Game rules
  localparam int NUM_BOMB_SLOTS  = 2;
  localparam int FUSE_FRAMES     = 3;
  localparam int PLAYER_INIT_COL = 1;
  localparam int PLAYER_INIT_ROW = 1;
  // Centre plus four neighbours
  localparam int BLAST_WRITES    = 5;

  typedef logic [9:0]            pix_x_t;
  typedef logic [9:0]            pix_y_t;
  typedef logic [4:0]            tile_col_t;
  typedef logic [3:0]            tile_row_t;
  typedef logic [MAP_ADDR_W-1:0] map_addr_t;
  typedef logic [1:0]            tile_t;
  typedef logic [11:0]           rgb_t;
  typedef logic [$clog2(FUSE_FRAMES+1)-1:0] fuse_cnt_t;
  typedef logic [2:0]            blast_step_t;

  localparam tile_t TILE_EMPTY = 2'd0;
  localparam tile_t TILE_HARD  = 2'd1;
  localparam tile_t TILE_SOFT  = 2'd2;
  localparam tile_t TILE_BOMB  = 2'd3;

  // Colors packed as {r, g, b}
  localparam rgb_t C_EMPTY  = 12'h000;
  localparam rgb_t C_HARD   = 12'hFFF;
  localparam rgb_t C_SOFT   = 12'h00F;
  localparam rgb_t C_BOMB   = 12'hF00;
  localparam rgb_t C_PLAYER = 12'h0F0;

  function automatic map_addr_t tile_addr(input tile_row_t row, input tile_col_t col);
    return map_addr_t'(int'(row) * MAP_COLS + int'(col));
  endfunction

  // Border ring plus the grid of pillars on even row and even column
  function automatic logic is_hard_wall(input tile_row_t row, input tile_col_t col);
    logic border;
    border = (row == 0) || (row == MAP_ROWS - 1) || (col == 0) || (col == MAP_COLS - 1);
    return border || (!row[0] && !col[0]);
  endfunction

  function automatic tile_t init_tile(input tile_row_t row, input tile_col_t col);
    logic in_corner;
    in_corner = (row >= 1) && (row <= 3) && (col >= 1) && (col <= 3);
    if (is_hard_wall(row, col)) begin
      return TILE_HARD;
    end
    // Keep the start corner free so the player can move
    if (((int'(row) + int'(col)) % 3 == 0) && !in_corner) begin
      return TILE_SOFT;
    end
    return TILE_EMPTY;
  endfunction

endpackage

`default_nettype wire
